//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
common/ex_pkg.sv
alu/fu_alu.sv
mult/mult_stage.sv
mult/fu_mult.sv
complete/complete_buffer.sv
verilog/ex_stage.sv
verif/ex_stage_tb.sv

//--- alu/fu_alu.sv
`timescale 1ns/1ps

module fu_alu (
    input  logic              clock,
    input  logic              reset,
    input  logic              clear_i,
    input  logic              valid_i,
    input  ex_pkg::fu_unit_t  unit_i,
    input  ex_pkg::fu_op_u    op_i,
    input  ex_pkg::xlen_t     opa_i,
    input  ex_pkg::xlen_t     opb_i,
    input  ex_pkg::xlen_t     npc_i,
    input  logic              halt_i,
    input  ex_pkg::rob_tag_t  tag_i,
    input  logic              slot_busy_i,
    output logic              result_valid_o,
    output ex_pkg::rob_tag_t  tag_o,
    output ex_pkg::xlen_t     value_o,
    output ex_pkg::xlen_t     npc_o,
    output logic              halt_o,
    output logic              branch_taken_o,
    output logic              ready_o
);
    import ex_pkg::*;

    logic  accept;
    logic  stall;
    xlen_t alu_value;
    logic  alu_taken;

    assign accept  = valid_i && (unit_i == UNIT_ALU);
    assign stall   = result_valid_o && slot_busy_i; // result waiting on the buffer
    assign ready_o = !stall;

    always_comb begin
        alu_value = '0;
        alu_taken = 1'b0;
        case (op_i.alu)
            ADD: alu_value = opa_i + opb_i;
            SUB: alu_value = opa_i - opb_i;
            AND: alu_value = opa_i & opb_i;
            OR:  alu_value = opa_i | opb_i;
            XOR: alu_value = opa_i ^ opb_i;
            SLL: alu_value = opa_i << opb_i[$clog2(XLEN)-1:0];
            SRL: alu_value = opa_i >> opb_i[$clog2(XLEN)-1:0];
            SLT: alu_value = {{(XLEN-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
            BEQ: alu_taken = (opa_i == opb_i);
            BNE: alu_taken = (opa_i != opb_i);
            BLT: alu_taken = ($signed(opa_i) < $signed(opb_i));
            default: alu_value = '0;
        endcase
        if (alu_taken) begin
            alu_value = {{(XLEN-1){1'b0}}, 1'b1}; // compare result as the value
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            result_valid_o <= 1'b0;
        end else if (!stall) begin
            result_valid_o <= accept;
        end
    end

    // hold register, frozen while the slot is full
    always_ff @(posedge clock) begin
        if (!stall && accept) begin
            tag_o          <= tag_i;
            value_o        <= alu_value;
            npc_o          <= npc_i;
            halt_o         <= halt_i;
            branch_taken_o <= alu_taken;
        end
    end

    // issue logic must see ready before sending an alu op here
    issue_when_ready: assert property (@(posedge clock) disable iff (reset)
        accept |-> ready_o)
        else $error("alu issued while its result is stalled");

endmodule

//--- common/ex_pkg.sv
package ex_pkg;

    localparam int XLEN        = 32;
    localparam int ISSUE_WIDTH = 3;
    localparam int NUM_FU_ALU  = 3;
    localparam int NUM_FU_MULT = 3;
    localparam int COMP_SLOTS  = NUM_FU_MULT + NUM_FU_ALU; // mult slots first, then alu
    localparam int ROB_TAG_W   = 5;                        // 32-entry rob
    localparam int MULT_STAGES = 4;
    localparam int MULT_SLICE  = 8;                        // multiplier bits per stage

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    typedef enum logic {
        UNIT_ALU  = 1'b0,
        UNIT_MULT = 1'b1
    } fu_unit_t;

    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR  = 4'h3,
        XOR = 4'h4,
        SLL = 4'h5,
        SRL = 4'h6,
        SLT = 4'h7,  // signed
        BEQ = 4'h8,
        BNE = 4'h9,
        BLT = 4'ha   // signed compare
    } alu_func_t;

    typedef enum logic [3:0] {
        MUL   = 4'h0, // low word
        MULHU = 4'h1  // unsigned high word
    } mult_func_t;

    // one issue field, read by whichever unit takes the lane
    typedef union packed {
        alu_func_t  alu;
        mult_func_t mult;
    } fu_op_u;

endpackage

//--- complete/complete_buffer.sv
`timescale 1ns/1ps

module complete_buffer (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          clear_i,
    input  logic [ex_pkg::COMP_SLOTS-1:0]                 fu_valid_i,
    input  ex_pkg::rob_tag_t [ex_pkg::COMP_SLOTS-1:0]     fu_tag_i,
    input  ex_pkg::xlen_t [ex_pkg::COMP_SLOTS-1:0]        fu_value_i,
    input  ex_pkg::xlen_t [ex_pkg::COMP_SLOTS-1:0]        fu_npc_i,
    input  logic [ex_pkg::COMP_SLOTS-1:0]                 fu_halt_i,
    input  logic [ex_pkg::COMP_SLOTS-1:0]                 fu_branch_taken_i,
    output logic [ex_pkg::COMP_SLOTS-1:0]                 slot_busy_o,
    output logic [ex_pkg::ISSUE_WIDTH-1:0]                cdb_valid_o,
    output ex_pkg::rob_tag_t [ex_pkg::ISSUE_WIDTH-1:0]    cdb_tag_o,
    output ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       cdb_value_o,
    output ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       cdb_npc_o,
    output logic [ex_pkg::ISSUE_WIDTH-1:0]                cdb_halt_o,
    output logic [ex_pkg::ISSUE_WIDTH-1:0]                cdb_branch_taken_o
);
    import ex_pkg::*;

    logic     [COMP_SLOTS-1:0] slot_valid;
    logic     [COMP_SLOTS-1:0] occ;   // held entry or one arriving now
    logic     [COMP_SLOTS-1:0] pick;  // sent on the bus this cycle
    rob_tag_t [COMP_SLOTS-1:0] slot_tag, eff_tag;
    xlen_t    [COMP_SLOTS-1:0] slot_value, eff_value;
    xlen_t    [COMP_SLOTS-1:0] slot_npc, eff_npc;
    logic     [COMP_SLOTS-1:0] slot_halt, eff_halt;
    logic     [COMP_SLOTS-1:0] slot_br, eff_br;

    logic     [ISSUE_WIDTH-1:0] cdb_valid_d;
    rob_tag_t [ISSUE_WIDTH-1:0] cdb_tag_d;
    xlen_t    [ISSUE_WIDTH-1:0] cdb_value_d;
    xlen_t    [ISSUE_WIDTH-1:0] cdb_npc_d;
    logic     [ISSUE_WIDTH-1:0] cdb_halt_d;
    logic     [ISSUE_WIDTH-1:0] cdb_br_d;

    assign occ = slot_valid | fu_valid_i;

    // a free slot takes whatever the unit presents
    always_comb begin
        for (int s = 0; s < COMP_SLOTS; s++) begin
            eff_tag[s]   = slot_valid[s] ? slot_tag[s]   : fu_tag_i[s];
            eff_value[s] = slot_valid[s] ? slot_value[s] : fu_value_i[s];
            eff_npc[s]   = slot_valid[s] ? slot_npc[s]   : fu_npc_i[s];
            eff_halt[s]  = slot_valid[s] ? slot_halt[s]  : fu_halt_i[s];
            eff_br[s]    = slot_valid[s] ? slot_br[s]    : fu_branch_taken_i[s];
        end
    end

    // lowest slots first, so multiplies beat alu results
    always_comb begin
        int lane;
        lane        = 0;
        pick        = '0;
        cdb_valid_d = '0;
        cdb_tag_d   = '0;
        cdb_value_d = '0;
        cdb_npc_d   = '0;
        cdb_halt_d  = '0;
        cdb_br_d    = '0;
        for (int s = 0; s < COMP_SLOTS; s++) begin
            if (occ[s] && lane < ISSUE_WIDTH) begin
                pick[s]           = 1'b1;
                cdb_valid_d[lane] = 1'b1;
                cdb_tag_d[lane]   = eff_tag[s];
                cdb_value_d[lane] = eff_value[s];
                cdb_npc_d[lane]   = eff_npc[s];
                cdb_halt_d[lane]  = eff_halt[s];
                cdb_br_d[lane]    = eff_br[s];
                lane              = lane + 1;
            end
        end
    end

    assign slot_busy_o = occ & ~pick; // still occupied after this cycle

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            slot_valid  <= '0;
            cdb_valid_o <= '0;
        end else begin
            slot_valid  <= slot_busy_o;
            cdb_valid_o <= cdb_valid_d;
        end
    end

    always_ff @(posedge clock) begin
        slot_tag           <= eff_tag;
        slot_value         <= eff_value;
        slot_npc           <= eff_npc;
        slot_halt          <= eff_halt;
        slot_br            <= eff_br;
        cdb_tag_o          <= cdb_tag_d;
        cdb_value_o        <= cdb_value_d;
        cdb_npc_o          <= cdb_npc_d;
        cdb_halt_o         <= cdb_halt_d;
        cdb_branch_taken_o <= cdb_br_d;
    end

    // tags are unique in the rob, so two lanes never carry the same one
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_tag_a
        for (genvar j = i + 1; j < ISSUE_WIDTH; j++) begin : g_tag_b
            unique_cdb_tag: assert property (@(posedge clock) disable iff (reset)
                (cdb_valid_o[i] && cdb_valid_o[j]) |-> (cdb_tag_o[i] != cdb_tag_o[j]))
                else $error("tag %0h on cdb lanes %0d and %0d", cdb_tag_o[i], i, j);
        end
    end

endmodule

//--- mult/fu_mult.sv
`timescale 1ns/1ps

module fu_mult (
    input  logic              clock,
    input  logic              reset,
    input  logic              clear_i,
    input  logic              valid_i,
    input  ex_pkg::fu_unit_t  unit_i,
    input  ex_pkg::fu_op_u    op_i,
    input  ex_pkg::xlen_t     opa_i,
    input  ex_pkg::xlen_t     opb_i,
    input  ex_pkg::xlen_t     npc_i,
    input  logic              halt_i,
    input  ex_pkg::rob_tag_t  tag_i,
    input  logic              slot_busy_i,
    output logic              result_valid_o,
    output ex_pkg::rob_tag_t  tag_o,
    output ex_pkg::xlen_t     value_o,
    output ex_pkg::xlen_t     npc_o,
    output logic              halt_o,
    output logic              ready_o
);
    import ex_pkg::*;

    logic accept;
    logic stall;
    logic high;

    // chain taps, index 0 is the issue side
    logic     [MULT_STAGES:0]             valid_c;
    logic     [MULT_STAGES:0]             halt_c;
    logic     [MULT_STAGES:0]             high_c;
    rob_tag_t [MULT_STAGES:0]             tag_c;
    xlen_t    [MULT_STAGES:0]             npc_c;
    xlen_t    [MULT_STAGES:0]             mcand_c;
    xlen_t    [MULT_STAGES:0]             mplier_c;
    logic     [MULT_STAGES:0][2*XLEN-1:0] partial_c;

    assign accept  = valid_i && (unit_i == UNIT_MULT);
    assign high    = (op_i.mult == MULHU);
    assign stall   = valid_c[MULT_STAGES] && slot_busy_i; // freezes every stage
    assign ready_o = !stall;

    assign valid_c[0]   = accept;
    assign halt_c[0]    = halt_i;
    assign high_c[0]    = high;
    assign tag_c[0]     = tag_i;
    assign npc_c[0]     = npc_i;
    assign mcand_c[0]   = opa_i;
    assign mplier_c[0]  = opb_i;
    assign partial_c[0] = '0;

    for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
        mult_stage #(
            .STAGE(s)
        ) u_stage (
            .clock     (clock),
            .reset     (reset),
            .clear_i   (clear_i),
            .stall_i   (stall),
            .valid_i   (valid_c[s]),
            .tag_i     (tag_c[s]),
            .npc_i     (npc_c[s]),
            .halt_i    (halt_c[s]),
            .high_i    (high_c[s]),
            .mcand_i   (mcand_c[s]),
            .mplier_i  (mplier_c[s]),
            .partial_i (partial_c[s]),
            .valid_o   (valid_c[s+1]),
            .tag_o     (tag_c[s+1]),
            .npc_o     (npc_c[s+1]),
            .halt_o    (halt_c[s+1]),
            .high_o    (high_c[s+1]),
            .mcand_o   (mcand_c[s+1]),
            .mplier_o  (mplier_c[s+1]),
            .partial_o (partial_c[s+1])
        );
    end

    assign result_valid_o = valid_c[MULT_STAGES];
    assign tag_o          = tag_c[MULT_STAGES];
    assign npc_o          = npc_c[MULT_STAGES];
    assign halt_o         = halt_c[MULT_STAGES];
    assign value_o        = high_c[MULT_STAGES] ? partial_c[MULT_STAGES][2*XLEN-1:XLEN]
                                                : partial_c[MULT_STAGES][XLEN-1:0];

    // a stalled chain cannot take a new multiply at stage 0
    issue_when_ready: assert property (@(posedge clock) disable iff (reset)
        accept |-> ready_o)
        else $error("multiply issued while the stage chain is frozen");

endmodule

//--- mult/mult_stage.sv
`timescale 1ns/1ps

module mult_stage #(
    parameter int STAGE = 0 // slice index, sets where this partial product lands
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       clear_i,
    input  logic                       stall_i,
    input  logic                       valid_i,
    input  ex_pkg::rob_tag_t           tag_i,
    input  ex_pkg::xlen_t              npc_i,
    input  logic                       halt_i,
    input  logic                       high_i,
    input  ex_pkg::xlen_t              mcand_i,
    input  ex_pkg::xlen_t              mplier_i,
    input  logic [2*ex_pkg::XLEN-1:0]  partial_i,
    output logic                       valid_o,
    output ex_pkg::rob_tag_t           tag_o,
    output ex_pkg::xlen_t              npc_o,
    output logic                       halt_o,
    output logic                       high_o,
    output ex_pkg::xlen_t              mcand_o,
    output ex_pkg::xlen_t              mplier_o,
    output logic [2*ex_pkg::XLEN-1:0]  partial_o
);
    import ex_pkg::*;

    logic [2*XLEN-1:0] slice_prod;

    // mcand times the low slice of mplier, shifted into place
    assign slice_prod = ({{XLEN{1'b0}}, mcand_i}
                         * {{(2*XLEN-MULT_SLICE){1'b0}}, mplier_i[MULT_SLICE-1:0]})
                        << (STAGE * MULT_SLICE);

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall_i) begin
            tag_o     <= tag_i;
            npc_o     <= npc_i;
            halt_o    <= halt_i;
            high_o    <= high_i;
            mcand_o   <= mcand_i;
            mplier_o  <= mplier_i >> MULT_SLICE; // next slice moves down
            partial_o <= partial_i + slice_prod;
        end
    end

endmodule

//--- verif/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;
    import ex_pkg::*;

    localparam int MAX_TESTS       = 32;
    localparam int NUM_TAGS        = 2 ** ROB_TAG_W;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_TEST = 20;

    typedef struct {
        int       gap;       // cycles after the previous entry, 0 shares its cycle
        logic     flush;     // pulse clear_i instead of issuing
        int       lane;
        fu_unit_t unit;
        fu_op_u   op;
        xlen_t    opa;
        xlen_t    opb;
        xlen_t    npc;
        logic     halt;
        rob_tag_t tag;
        xlen_t    exp_value;
        logic     exp_br;
        int       exp_lat;   // 0 where contention makes it vary
    } entry_t;

    logic                                 clock;
    logic                                 reset;
    logic                                 clear_i;
    logic [ISSUE_WIDTH-1:0]               is_valid_i;
    fu_unit_t [ISSUE_WIDTH-1:0]           is_unit_i;
    fu_op_u [ISSUE_WIDTH-1:0]             is_op_i;
    xlen_t [ISSUE_WIDTH-1:0]              is_opa_i;
    xlen_t [ISSUE_WIDTH-1:0]              is_opb_i;
    xlen_t [ISSUE_WIDTH-1:0]              is_npc_i;
    logic [ISSUE_WIDTH-1:0]               is_halt_i;
    rob_tag_t [ISSUE_WIDTH-1:0]           is_tag_i;
    logic [ISSUE_WIDTH-1:0]               cdb_valid_o;
    rob_tag_t [ISSUE_WIDTH-1:0]           cdb_tag_o;
    xlen_t [ISSUE_WIDTH-1:0]              cdb_value_o;
    xlen_t [ISSUE_WIDTH-1:0]              cdb_npc_o;
    logic [ISSUE_WIDTH-1:0]               cdb_halt_o;
    logic [ISSUE_WIDTH-1:0]               cdb_branch_taken_o;
    logic [NUM_FU_ALU-1:0]                alu_ready_o;
    logic [NUM_FU_MULT-1:0]               mult_ready_o;

    entry_t tbl [MAX_TESTS];
    int     num_tests   = 0;
    int     seed        = 32'h4a9e;
    int     cycle       = 0;
    int     outstanding = 0;
    int     errors      = 0;
    int     passed      = 0;
    int     failed      = 0;
    int     flushed_cnt = 0;
    logic   table_ready = 1'b0;

    // scoreboard, indexed by rob tag
    int     tag_idx   [NUM_TAGS];
    int     issue_cyc [NUM_TAGS];
    logic   seen      [NUM_TAGS];
    logic   flushed   [NUM_TAGS];

    // issued tags per unit, oldest first, numbered like the buffer slots
    rob_tag_t unit_q [COMP_SLOTS][$];

    ex_stage DUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    function automatic logic ref_taken(logic [3:0] code, xlen_t a, xlen_t b);
        case (code)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlen_t ref_value(fu_unit_t unit, logic [3:0] code, xlen_t a, xlen_t b);
        logic [2*XLEN-1:0] prod;
        prod = {32'b0, a} * {32'b0, b}; // unsigned full product
        if (unit == UNIT_MULT) begin
            return (code == MULHU) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end
        case (code)
            ADD:           return a + b;
            SUB:           return a - b;
            AND:           return a & b;
            OR:            return a | b;
            XOR:           return a ^ b;
            SLL:           return a << b[4:0];
            SRL:           return a >> b[4:0];
            SLT:           return {31'b0, $signed(a) < $signed(b)};
            BEQ, BNE, BLT: return {31'b0, ref_taken(code, a, b)};
            default:       return '0;
        endcase
    endfunction

    task automatic add_entry(int gap, int lane, fu_unit_t unit, logic [3:0] code,
                             xlen_t a, xlen_t b, logic halt, int lat);
        entry_t e;
        e.gap       = gap;
        e.flush     = 1'b0;
        e.lane      = lane;
        e.unit      = unit;
        e.op        = code;
        e.opa       = a;
        e.opb       = b;
        e.npc       = 32'h0000_1000 + 4 * num_tests;
        e.halt      = halt;
        e.tag       = rob_tag_t'(num_tests);
        e.exp_value = ref_value(unit, code, a, b);
        e.exp_br    = (unit == UNIT_ALU) ? ref_taken(code, a, b) : 1'b0;
        e.exp_lat   = lat;
        tbl[num_tests] = e;
        num_tests++;
    endtask

    task automatic add_clear(int gap);
        tbl[num_tests].gap   = gap;
        tbl[num_tests].flush = 1'b1;
        num_tests++;
    endtask

    task automatic build_table();
        // plain alu ops, one per cycle
        add_entry(1, 0, UNIT_ALU, ADD, 32'h0000_1234, 32'h0000_0f0f, 1'b0, 2);
        add_entry(1, 1, UNIT_ALU, SUB, 32'h0000_0005, 32'h0000_0009, 1'b0, 2);
        add_entry(1, 2, UNIT_ALU, AND, $random(seed), $random(seed), 1'b0, 2);
        add_entry(1, 0, UNIT_ALU, OR, $random(seed), $random(seed), 1'b0, 2);
        add_entry(1, 1, UNIT_ALU, XOR, $random(seed), $random(seed), 1'b0, 2);
        add_entry(1, 2, UNIT_ALU, SLL, $random(seed), $random(seed), 1'b0, 2);
        add_entry(1, 0, UNIT_ALU, SRL, 32'hf000_0000, 32'd28, 1'b0, 2);
        add_entry(1, 1, UNIT_ALU, SLT, 32'hffff_fff0, 32'd3, 1'b0, 2);
        // multiplies, the first two back to back on one unit
        add_entry(3, 0, UNIT_MULT, MUL, $random(seed), $random(seed), 1'b0, 5);
        add_entry(1, 0, UNIT_MULT, MULHU, $random(seed), $random(seed), 1'b0, 5);
        add_entry(1, 2, UNIT_MULT, MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 5);
        // branches, one carrying halt
        add_entry(1, 0, UNIT_ALU, BEQ, 32'h0000_0055, 32'h0000_0055, 1'b0, 2);
        add_entry(1, 1, UNIT_ALU, BNE, 32'h0000_0055, 32'h0000_0055, 1'b0, 2);
        add_entry(1, 2, UNIT_ALU, BLT, 32'hffff_fffe, 32'h0000_0001, 1'b1, 2);
        add_entry(1, 0, UNIT_ALU, BLT, 32'h0000_0007, 32'h0000_0002, 1'b0, 2);
        // six results land together, alus must wait a cycle
        add_entry(6, 0, UNIT_MULT, MUL, $random(seed), $random(seed), 1'b0, 5);
        add_entry(0, 1, UNIT_MULT, MULHU, $random(seed), $random(seed), 1'b0, 5);
        add_entry(0, 2, UNIT_MULT, MUL, $random(seed), $random(seed), 1'b0, 5);
        add_entry(3, 0, UNIT_ALU, ADD, $random(seed), $random(seed), 1'b0, 0);
        add_entry(0, 1, UNIT_ALU, XOR, $random(seed), $random(seed), 1'b0, 0);
        add_entry(0, 2, UNIT_ALU, SUB, $random(seed), $random(seed), 1'b0, 0);
        add_entry(1, 0, UNIT_ALU, OR, $random(seed), $random(seed), 1'b0, 2);
        // flush while two alu results still wait behind multiplies
        add_entry(6, 0, UNIT_MULT, MUL, $random(seed), $random(seed), 1'b0, 0);
        add_entry(0, 1, UNIT_MULT, MULHU, $random(seed), $random(seed), 1'b0, 0);
        add_entry(0, 2, UNIT_MULT, MUL, $random(seed), $random(seed), 1'b0, 0);
        add_entry(1, 0, UNIT_MULT, MUL, $random(seed), $random(seed), 1'b0, 0);
        add_entry(0, 1, UNIT_MULT, MULHU, $random(seed), $random(seed), 1'b0, 0);
        add_entry(2, 1, UNIT_ALU, ADD, $random(seed), $random(seed), 1'b0, 0);
        add_entry(0, 2, UNIT_ALU, XOR, $random(seed), $random(seed), 1'b0, 0);
        add_clear(1);
        add_entry(2, 0, UNIT_ALU, SUB, $random(seed), $random(seed), 1'b0, 2);
    endtask

    task automatic check_value(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("ERR %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(string name, rob_tag_t got, rob_tag_t exp);
        if (got !== exp) begin
            $display("ERR %s got %02h expected %02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic unit_ready(int lane, fu_unit_t unit);
        return (unit == UNIT_MULT) ? mult_ready_o[lane] : alu_ready_o[lane];
    endfunction

    function automatic int unit_slot(int lane, fu_unit_t unit);
        return (unit == UNIT_MULT) ? lane : NUM_FU_MULT + lane;
    endfunction

    // hold the whole group until every unit it targets is ready
    task automatic wait_group_ready(int first);
        int   j;
        logic ok;
        ok = 1'b0;
        while (!ok) begin
            ok = 1'b1;
            j  = first;
            while (j == first || (j < num_tests && tbl[j].gap == 0)) begin
                if (!unit_ready(tbl[j].lane, tbl[j].unit)) begin
                    ok = 1'b0;
                end
                j++;
            end
            if (!ok) begin
                @(negedge clock);
            end
        end
    endtask

    task automatic issue_entry(int i);
        int       l;
        rob_tag_t t;
        l = tbl[i].lane;
        t = tbl[i].tag;
        is_valid_i[l] = 1'b1;
        is_unit_i[l]  = tbl[i].unit;
        is_op_i[l]    = tbl[i].op;
        is_opa_i[l]   = tbl[i].opa;
        is_opb_i[l]   = tbl[i].opb;
        is_npc_i[l]   = tbl[i].npc;
        is_halt_i[l]  = tbl[i].halt;
        is_tag_i[l]   = t;
        tag_idx[t]    = i;
        issue_cyc[t]  = cycle;
        unit_q[unit_slot(l, tbl[i].unit)].push_back(t);
        outstanding++;
    endtask

    task automatic pulse_clear(int i);
        clear_i = 1'b1;
        @(posedge clock);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (tag_idx[t] >= 0 && !seen[t] && !flushed[t]) begin
                flushed[t] = 1'b1;
                outstanding--;
                flushed_cnt++;
                $display("test %0d tag %02h flushed by clear", tag_idx[t], t);
            end
        end
        for (int u = 0; u < COMP_SLOTS; u++) begin
            unit_q[u].delete();
        end
        @(negedge clock);
        clear_i = 1'b0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            check_flag($sformatf("alu_ready_o[%0d]", l), alu_ready_o[l], 1'b1);
            check_flag($sformatf("mult_ready_o[%0d]", l), mult_ready_o[l], 1'b1);
        end
        $display("test %0d clear pulsed, ready outputs checked", i);
    endtask

    task automatic check_cdb();
        logic     saw_alu;
        rob_tag_t t;
        int       i;
        int       u;
        int       err_before;
        saw_alu = 1'b0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (cdb_valid_o[l]) begin
                t = cdb_tag_o[l];
                i = tag_idx[t];
                if (flushed[t]) begin
                    $display("flushed tag %02h showed up on cdb lane %0d", t, l);
                    errors++;
                end else if (i < 0) begin
                    $display("tag %02h on cdb lane %0d was never issued", t, l);
                    errors++;
                end else if (seen[t]) begin
                    $display("tag %02h appeared on the cdb a second time", t);
                    errors++;
                end else begin
                    err_before = errors;
                    seen[t]    = 1'b1;
                    outstanding--;
                    // each unit finishes its own work in issue order
                    u = unit_slot(tbl[i].lane, tbl[i].unit);
                    check_tag($sformatf("cdb_tag_o[%0d]", l), t, unit_q[u].pop_front());
                    check_value($sformatf("cdb_value_o[%0d]", l), cdb_value_o[l],
                                tbl[i].exp_value);
                    check_value($sformatf("cdb_npc_o[%0d]", l), cdb_npc_o[l], tbl[i].npc);
                    check_flag($sformatf("cdb_halt_o[%0d]", l), cdb_halt_o[l], tbl[i].halt);
                    check_flag($sformatf("cdb_branch_taken_o[%0d]", l),
                               cdb_branch_taken_o[l], tbl[i].exp_br);
                    if (tbl[i].exp_lat != 0 && cycle - issue_cyc[t] != tbl[i].exp_lat) begin
                        $display("tag %02h finished %0d cycles after issue, %0d expected",
                                 t, cycle - issue_cyc[t], tbl[i].exp_lat);
                        errors++;
                    end
                    if (tbl[i].unit == UNIT_MULT && saw_alu) begin
                        $display("multiply tag %02h on lane %0d behind an alu result", t, l);
                        errors++;
                    end
                    saw_alu = saw_alu || (tbl[i].unit == UNIT_ALU);
                    if (errors == err_before) begin
                        passed++;
                        $display("test %0d tag %02h ok after %0d cycles", i, t,
                                 cycle - issue_cyc[t]);
                    end else begin
                        failed++;
                        $display("test %0d tag %02h FAILED", i, t);
                    end
                end
            end
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            check_cdb();
        end
    end

    initial begin
        reset      = 1'b1;
        clear_i    = 1'b0;
        is_valid_i = '0;
        is_op_i    = '0;
        is_opa_i   = '0;
        is_opb_i   = '0;
        is_npc_i   = '0;
        is_halt_i  = '0;
        is_tag_i   = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            is_unit_i[l] = UNIT_ALU;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_idx[t] = -1;
            seen[t]    = 1'b0;
            flushed[t] = 1'b0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            repeat (tbl[i].gap) begin
                @(negedge clock);
                is_valid_i = '0;
            end
            if (tbl[i].flush) begin
                pulse_clear(i);
            end else begin
                if (tbl[i].gap > 0) begin
                    wait_group_ready(i);
                end
                issue_entry(i);
            end
        end
        @(negedge clock);
        is_valid_i = '0;
        wait (outstanding == 0);
        repeat (10) @(negedge clock); // late or flushed tags would show here
        $display("results: %0d passed, %0d failed, %0d flushed, %0d errors",
                 passed, failed, flushed_cnt, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + num_tests * CYCLES_PER_TEST) @(posedge clock);
        $display("timeout after %0d cycles, %0d results never reached the cdb",
                 cycle, outstanding);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          clear_i,
    input  logic [ex_pkg::ISSUE_WIDTH-1:0]                is_valid_i,
    input  ex_pkg::fu_unit_t [ex_pkg::ISSUE_WIDTH-1:0]    is_unit_i,
    input  ex_pkg::fu_op_u [ex_pkg::ISSUE_WIDTH-1:0]      is_op_i,
    input  ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       is_opa_i,
    input  ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       is_opb_i,
    input  ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       is_npc_i,
    input  logic [ex_pkg::ISSUE_WIDTH-1:0]                is_halt_i,
    input  ex_pkg::rob_tag_t [ex_pkg::ISSUE_WIDTH-1:0]    is_tag_i,
    output logic [ex_pkg::ISSUE_WIDTH-1:0]                cdb_valid_o,
    output ex_pkg::rob_tag_t [ex_pkg::ISSUE_WIDTH-1:0]    cdb_tag_o,
    output ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       cdb_value_o,
    output ex_pkg::xlen_t [ex_pkg::ISSUE_WIDTH-1:0]       cdb_npc_o,
    output logic [ex_pkg::ISSUE_WIDTH-1:0]                cdb_halt_o,
    output logic [ex_pkg::ISSUE_WIDTH-1:0]                cdb_branch_taken_o,
    output logic [ex_pkg::NUM_FU_ALU-1:0]                 alu_ready_o,
    output logic [ex_pkg::NUM_FU_MULT-1:0]                mult_ready_o
);
    import ex_pkg::*;

    // per-slot result wires, mult units on 0..2 and alus on 3..5
    logic     [COMP_SLOTS-1:0] slot_valid;
    rob_tag_t [COMP_SLOTS-1:0] slot_tag;
    xlen_t    [COMP_SLOTS-1:0] slot_value;
    xlen_t    [COMP_SLOTS-1:0] slot_npc;
    logic     [COMP_SLOTS-1:0] slot_halt;
    logic     [COMP_SLOTS-1:0] slot_busy;
    logic     [NUM_FU_ALU-1:0] alu_branch_taken;

    // lane i reaches only mult i and alu i
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        fu_mult u_mult (
            .clock          (clock),
            .reset          (reset),
            .clear_i        (clear_i),
            .valid_i        (is_valid_i[i]),
            .unit_i         (is_unit_i[i]),
            .op_i           (is_op_i[i]),
            .opa_i          (is_opa_i[i]),
            .opb_i          (is_opb_i[i]),
            .npc_i          (is_npc_i[i]),
            .halt_i         (is_halt_i[i]),
            .tag_i          (is_tag_i[i]),
            .slot_busy_i    (slot_busy[i]),
            .result_valid_o (slot_valid[i]),
            .tag_o          (slot_tag[i]),
            .value_o        (slot_value[i]),
            .npc_o          (slot_npc[i]),
            .halt_o         (slot_halt[i]),
            .ready_o        (mult_ready_o[i])
        );

        fu_alu u_alu (
            .clock          (clock),
            .reset          (reset),
            .clear_i        (clear_i),
            .valid_i        (is_valid_i[i]),
            .unit_i         (is_unit_i[i]),
            .op_i           (is_op_i[i]),
            .opa_i          (is_opa_i[i]),
            .opb_i          (is_opb_i[i]),
            .npc_i          (is_npc_i[i]),
            .halt_i         (is_halt_i[i]),
            .tag_i          (is_tag_i[i]),
            .slot_busy_i    (slot_busy[NUM_FU_MULT+i]),
            .result_valid_o (slot_valid[NUM_FU_MULT+i]),
            .tag_o          (slot_tag[NUM_FU_MULT+i]),
            .value_o        (slot_value[NUM_FU_MULT+i]),
            .npc_o          (slot_npc[NUM_FU_MULT+i]),
            .halt_o         (slot_halt[NUM_FU_MULT+i]),
            .branch_taken_o (alu_branch_taken[i]),
            .ready_o        (alu_ready_o[i])
        );
    end

    complete_buffer u_complete (
        .clock              (clock),
        .reset              (reset),
        .clear_i            (clear_i),
        .fu_valid_i         (slot_valid),
        .fu_tag_i           (slot_tag),
        .fu_value_i         (slot_value),
        .fu_npc_i           (slot_npc),
        .fu_halt_i          (slot_halt),
        .fu_branch_taken_i  ({alu_branch_taken, {NUM_FU_MULT{1'b0}}}), // multiplies never branch
        .slot_busy_o        (slot_busy),
        .cdb_valid_o        (cdb_valid_o),
        .cdb_tag_o          (cdb_tag_o),
        .cdb_value_o        (cdb_value_o),
        .cdb_npc_o          (cdb_npc_o),
        .cdb_halt_o         (cdb_halt_o),
        .cdb_branch_taken_o (cdb_branch_taken_o)
    );

endmodule
